//--- include/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// data word and address word
`define DC_WORD_W 32

// sets per way
`define DC_SETS 8

// set index bits, log2 of DC_SETS
`define DC_IDX_W 3

// address bits above index, block offset and byte offset
`define DC_TAG_W 26

// words in one block
`define DC_BLK_WORDS 2

// associativity
`define DC_WAYS 2

`endif

//--- hdl/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_TAG_W-1:0]  tag_t;
    typedef logic [`DC_IDX_W-1:0]  idx_t;
    typedef logic                  way_t;

    // byte address split for lookup
    typedef struct packed {
        tag_t       tag;
        idx_t       idx;
        logic       blkoff;
        logic [1:0] bytoff;
    } dcache_addr_t;

    // one block frame
    typedef struct packed {
        logic                          valid;
        logic                          dirty;
        tag_t                          tag;
        word_t [`DC_BLK_WORDS-1:0]     data;
    } frame_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } core_req_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // frame selection from controller
    typedef struct packed {
        idx_t idx;
        tag_t tag;
        logic word;
        logic force_en;
        way_t force_way;
    } way_sel_t;

    // lookup result for the selected set
    typedef struct packed {
        logic  hit;
        way_t  way;
        logic  valid;
        logic  dirty;
        tag_t  tag;
        word_t rdata;
    } way_stat_t;

    // frame update command
    typedef struct packed {
        logic  store;
        logic  fill;
        logic  last;
        logic  clean;
        logic  touch;
        word_t data;
    } way_wr_t;

    typedef enum logic [3:0] {
        IDLE,
        WB0,
        WB1,
        FILL0,
        FILL1,
        FLUSH_SCAN,
        FLUSH_WB0,
        FLUSH_WB1,
        DONE
    } ctrl_state_t;

endpackage

//--- hdl/dcache_ways.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ways
    import dcache_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  way_sel_t  sel,
    input  way_wr_t   wr,
    output way_stat_t stat
);

    // frame storage, one table per way
    frame_t tab [`DC_WAYS][`DC_SETS];

    // per set, the way to evict next
    way_t lru [`DC_SETS];

    logic [`DC_WAYS-1:0] way_hit;
    way_t                sel_way;
    frame_t              cur;

    // tag compare across all ways
    // no hits while the flush walker owns the selection
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = tab[w][sel.idx].valid &&
                         (tab[w][sel.idx].tag == sel.tag) &&
                         !sel.force_en;
        end
    end

    // way to act on
    // hit first, then forced way, then the lru victim
    always_comb begin
        sel_way = lru[sel.idx];
        if (sel.force_en) begin
            sel_way = sel.force_way;
        end
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (way_hit[w]) begin
                sel_way = way_t'(w);
            end
        end
    end

    assign cur = tab[sel_way][sel.idx];

    always_comb begin
        stat       = '0;
        stat.hit   = |way_hit;
        stat.way   = sel_way;
        stat.valid = cur.valid;
        stat.dirty = cur.dirty;
        stat.tag   = cur.tag;
        stat.rdata = cur.data[sel.word];
    end

    // frame and lru updates
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            tab <= '{default: '0};
            lru <= '{default: '0};
        end else begin
            // core write into a resident block
            if (wr.store) begin
                tab[sel_way][sel.idx].data[sel.word] <= wr.data;
                tab[sel_way][sel.idx].dirty          <= 1'b1;
            end

            // refill word from memory
            if (wr.fill) begin
                tab[sel_way][sel.idx].data[sel.word] <= wr.data;
                // block becomes resident with its last word
                if (wr.last) begin
                    tab[sel_way][sel.idx].tag   <= sel.tag;
                    tab[sel_way][sel.idx].valid <= 1'b1;
                    tab[sel_way][sel.idx].dirty <= 1'b0;
                end
            end

            // block now matches memory
            if (wr.clean) begin
                tab[sel_way][sel.idx].dirty <= 1'b0;
            end

            // other way becomes the victim
            if (wr.touch) begin
                lru[sel.idx] <= ~sel_way;
            end
        end
    end

endmodule

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  core_req_t core_req,
    input  logic      halt,
    input  way_stat_t stat,
    input  word_t     dload,
    input  logic      dwait,
    output way_sel_t  sel,
    output way_wr_t   wr,
    output logic      dhit,
    output word_t     dmemload,
    output logic      flushed,
    output mem_req_t  mem_req
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    // flush walker, set in upper bits, way in bit 0
    logic [`DC_IDX_W:0] fcnt;
    logic               fcnt_step;
    logic               fcnt_last;
    logic               flushing;

    dcache_addr_t req_addr;
    dcache_addr_t wb_addr;
    dcache_addr_t fill_addr;
    logic         req_on;

    assign req_addr  = core_req.addr;
    assign req_on    = core_req.ren | core_req.wen;
    assign fcnt_last = &fcnt;
    assign flushing  = (state == FLUSH_SCAN) ||
                       (state == FLUSH_WB0) ||
                       (state == FLUSH_WB1);

    // frame selection
    always_comb begin
        sel           = '0;
        sel.tag       = req_addr.tag;
        sel.force_en  = flushing;
        sel.force_way = fcnt[0];
        sel.idx       = flushing ? fcnt[`DC_IDX_W:1] : req_addr.idx;

        case (state)
            IDLE:                   sel.word = req_addr.blkoff;
            WB1, FILL1, FLUSH_WB1:  sel.word = 1'b1;
            default:                sel.word = 1'b0;
        endcase
    end

    // victim block address from its stored tag
    always_comb begin
        wb_addr        = '0;
        wb_addr.tag    = stat.tag;
        wb_addr.idx    = sel.idx;
        wb_addr.blkoff = sel.word;
    end

    // refill block address from the request
    always_comb begin
        fill_addr        = '0;
        fill_addr.tag    = req_addr.tag;
        fill_addr.idx    = req_addr.idx;
        fill_addr.blkoff = sel.word;
    end

    assign dmemload = stat.rdata;
    assign flushed  = (state == DONE);

    always_comb begin
        next_state = state;
        fcnt_step  = 1'b0;
        wr         = '0;
        mem_req    = '0;
        dhit       = 1'b0;

        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = FLUSH_SCAN;
                end else if (req_on) begin
                    if (stat.hit) begin
                        dhit     = 1'b1;
                        wr.touch = 1'b1;
                        wr.store = core_req.wen;
                        wr.data  = core_req.wdata;
                    end else if (stat.valid && stat.dirty) begin
                        next_state = WB0;
                    end else begin
                        next_state = FILL0;
                    end
                end
            end

            // victim write-back, one word per transfer
            WB0: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = wb_addr;
                mem_req.wdata = stat.rdata;
                if (!dwait) begin
                    next_state = WB1;
                end
            end

            WB1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = wb_addr;
                mem_req.wdata = stat.rdata;
                if (!dwait) begin
                    wr.clean   = 1'b1;
                    next_state = FILL0;
                end
            end

            FILL0: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = fill_addr;
                if (!dwait) begin
                    wr.fill    = 1'b1;
                    wr.data    = dload;
                    next_state = FILL1;
                end
            end

            // last word sets tag and valid, request hits next cycle
            FILL1: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = fill_addr;
                if (!dwait) begin
                    wr.fill    = 1'b1;
                    wr.last    = 1'b1;
                    wr.data    = dload;
                    next_state = IDLE;
                end
            end

            // walk all frames, skip clean ones
            FLUSH_SCAN: begin
                if (stat.dirty) begin
                    next_state = FLUSH_WB0;
                end else if (fcnt_last) begin
                    next_state = DONE;
                end else begin
                    fcnt_step = 1'b1;
                end
            end

            FLUSH_WB0: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = wb_addr;
                mem_req.wdata = stat.rdata;
                if (!dwait) begin
                    next_state = FLUSH_WB1;
                end
            end

            FLUSH_WB1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = wb_addr;
                mem_req.wdata = stat.rdata;
                if (!dwait) begin
                    wr.clean = 1'b1;
                    if (fcnt_last) begin
                        next_state = DONE;
                    end else begin
                        fcnt_step  = 1'b1;
                        next_state = FLUSH_SCAN;
                    end
                end
            end

            // held until reset
            DONE: begin
                next_state = DONE;
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            fcnt  <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE && halt) begin
                fcnt <= '0;
            end else if (fcnt_step) begin
                fcnt <= fcnt + 1'b1;
            end
        end
    end

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,

    // core side
    input  core_req_t core_req,
    input  logic      halt,
    output logic      dhit,
    output word_t     dmemload,
    output logic      flushed,

    // memory side
    output mem_req_t  mem_req,
    input  word_t     dload,
    input  logic      dwait
);

    // controller to storage
    way_sel_t  sel;
    way_wr_t   wr;
    way_stat_t stat;

    dcache_ways u_ways (
        .CLK  (CLK),
        .nRST (nRST),
        .sel  (sel),
        .wr   (wr),
        .stat (stat)
    );

    dcache_ctrl u_ctrl (
        .CLK      (CLK),
        .nRST     (nRST),
        .core_req (core_req),
        .halt     (halt),
        .stat     (stat),
        .dload    (dload),
        .dwait    (dwait),
        .sel      (sel),
        .wr       (wr),
        .dhit     (dhit),
        .dmemload (dmemload),
        .flushed  (flushed),
        .mem_req  (mem_req)
    );

endmodule

//--- bench/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk
    import dcache_pkg::*;
(
    input logic     CLK,
    input logic     nRST,
    input mem_req_t mem_req,
    input logic     dwait,
    input logic     flushed
);

    logic req_on;

    assign req_on = mem_req.ren | mem_req.wen;

    // one direction per transfer
    a_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else $error("memory ren and wen both high");

    // word aligned bus
    a_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        req_on |-> (mem_req.addr[1:0] == 2'b00))
        else $error("memory address has a byte offset");

    // request frozen while memory stalls
    a_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (req_on && dwait) |=> ($stable(mem_req.addr) && $stable(mem_req.wdata) &&
                               $stable(mem_req.ren) && $stable(mem_req.wen)))
        else $error("memory request changed while dwait high");

    a_flushed_hold: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> flushed)
        else $error("flushed fell before reset");

endmodule

//--- bench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    logic      CLK;
    logic      nRST;
    core_req_t core_req;
    logic      halt;
    logic      dhit;
    word_t     dmemload;
    logic      flushed;
    mem_req_t  mem_req;
    word_t     dload;
    logic      dwait;

    // memory model state
    word_t       mem [word_t];
    word_t       exp_img [word_t];
    word_t       rd_log [$];
    word_t       wr_log [$];
    logic        busy;
    int          wait_left;
    logic [15:0] lfsr;

    int checks;
    int errors;

    dcache_top uut (
        .CLK      (CLK),
        .nRST     (nRST),
        .core_req (core_req),
        .halt     (halt),
        .dhit     (dhit),
        .dmemload (dmemload),
        .flushed  (flushed),
        .mem_req  (mem_req),
        .dload    (dload),
        .dwait    (dwait)
    );

    bind dcache_top dcache_chk u_chk (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .dwait   (dwait),
        .flushed (flushed)
    );

    always #10 CLK = ~CLK;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // two lfsr bits give 0 to 3 wait cycles
    task automatic draw_wait(output int n);
        n = 0;
        for (int i = 0; i < 2; i++) begin
            n    = (n << 1) | int'(lfsr[15]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // untouched memory follows the fill rule
    function automatic word_t rule_word(input word_t a);
        return a ^ 32'hA5A50000;
    endfunction

    function automatic word_t mem_word(input word_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return rule_word(a);
    endfunction

    function automatic word_t expected_word(input word_t a);
        if (exp_img.exists(a)) begin
            return exp_img[a];
        end
        return rule_word(a);
    endfunction

    // new request draws its stall count
    always @(negedge CLK) begin
        if (mem_req.ren || mem_req.wen) begin
            if (!busy) begin
                busy = 1'b1;
                draw_wait(wait_left);
            end else if (wait_left > 0) begin
                wait_left--;
            end
            dwait = (wait_left != 0);
            dload = mem_word(mem_req.addr);
        end else begin
            busy  = 1'b0;
            dwait = 1'b0;
        end
    end

    // transfer completes on this edge
    always @(posedge CLK) begin
        if (nRST && !dwait && (mem_req.ren || mem_req.wen)) begin
            if (mem_req.wen) begin
                mem[mem_req.addr] = mem_req.wdata;
                wr_log.push_back(mem_req.addr);
            end else begin
                rd_log.push_back(mem_req.addr);
            end
            busy = 1'b0;
        end
    end

    task automatic check(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, errors - err_before);
        end
    endtask

    // one core access held until dhit
    task automatic access(input logic is_wr, input word_t addr, input word_t wdata,
                          output word_t rdata);
        int   n;
        logic got;
        n     = 0;
        got   = 1'b0;
        rdata = '0;
        @(negedge CLK);
        core_req.ren   = !is_wr;
        core_req.wen   = is_wr;
        core_req.addr  = addr;
        core_req.wdata = wdata;
        while (!got && n < 200) begin
            @(posedge CLK);
            if (dhit) begin
                got   = 1'b1;
                rdata = dmemload;
            end
            n++;
        end
        @(negedge CLK);
        core_req = '0;
        if (!got) begin
            errors++;
            $display("timeout: no dhit for access to address %h", addr);
        end
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        word_t unused;
        access(1'b1, addr, data, unused);
        exp_img[addr] = data;
    endtask

    task automatic clear_logs();
        rd_log.delete();
        wr_log.delete();
    endtask

    task automatic test_read_miss();
        int    e0;
        word_t d;
        e0 = errors;
        clear_logs();
        access(1'b0, 32'h104, '0, d);
        check("read miss data", expected_word(32'h104), d);
        check("read miss reads", 2, rd_log.size());
        if (rd_log.size() == 2) begin
            check("read miss addr0", 32'h100, rd_log[0]);
            check("read miss addr1", 32'h104, rd_log[1]);
        end
        check("read miss writes", 0, wr_log.size());
        finish_test("read miss", e0);
    endtask

    task automatic test_same_block();
        int    e0;
        word_t d;
        e0 = errors;
        clear_logs();
        access(1'b0, 32'h100, '0, d);
        check("same block data", expected_word(32'h100), d);
        check("same block traffic", 0, rd_log.size() + wr_log.size());
        finish_test("same block", e0);
    endtask

    task automatic test_write_hit();
        int    e0;
        word_t d;
        e0 = errors;
        clear_logs();
        write_word(32'h100, 32'hDEAD0001);
        access(1'b0, 32'h100, '0, d);
        check("write hit data", 32'hDEAD0001, d);
        check("write hit traffic", 0, rd_log.size() + wr_log.size());
        finish_test("write hit", e0);
    endtask

    // tags 1, 2, 3 all in set 2
    task automatic test_eviction();
        int    e0;
        word_t d;
        e0 = errors;
        write_word(32'h50, 32'h11110050);
        write_word(32'h94, 32'h22220094);
        // tag 2 becomes the lru way
        access(1'b0, 32'h50, '0, d);
        clear_logs();
        write_word(32'hD0, 32'h333300D0);
        check("evict writes", 2, wr_log.size());
        if (wr_log.size() == 2) begin
            check("evict wb addr0", 32'h90, wr_log[0]);
            check("evict wb addr1", 32'h94, wr_log[1]);
        end
        check("evict mem 94", 32'h22220094, mem_word(32'h94));
        check("evict mem 90", rule_word(32'h90), mem_word(32'h90));
        clear_logs();
        access(1'b0, 32'h50, '0, d);
        check("evict keep 50", 32'h11110050, d);
        check("evict keep traffic", 0, rd_log.size() + wr_log.size());
        access(1'b0, 32'h94, '0, d);
        check("evict refill 94", 32'h22220094, d);
        check("evict mem D0", 32'h333300D0, mem_word(32'hD0));
        finish_test("eviction", e0);
    endtask

    task automatic test_flush();
        int e0;
        int n;
        e0 = errors;
        n  = 0;
        clear_logs();
        @(negedge CLK);
        halt = 1'b1;
        while (!flushed && n < 1000) begin
            @(negedge CLK);
            n++;
        end
        if (!flushed) begin
            errors++;
            $display("timeout: flushed never rose after halt");
        end
        // blocks 0x100 and 0x50 are dirty
        check("flush writes", 4, wr_log.size());
        foreach (exp_img[a]) begin
            check($sformatf("flush image %h", a), exp_img[a], mem_word(a));
        end
        // every word written back matches the reference image
        foreach (mem[a]) begin
            check($sformatf("flush mem %h", a), expected_word(a), mem[a]);
        end
        @(negedge CLK);
        check("flushed held", 1, flushed);
        finish_test("flush", e0);
    endtask

    initial begin
        CLK       = 1'b0;
        nRST      = 1'b0;
        core_req  = '0;
        halt      = 1'b0;
        dload     = '0;
        dwait     = 1'b0;
        busy      = 1'b0;
        wait_left = 0;
        lfsr      = 16'd49195;
        checks    = 0;
        errors    = 0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        check("reset outputs", 0, {dhit, flushed, mem_req.ren, mem_req.wen});

        test_read_miss();
        test_same_block();
        test_write_hit();
        test_eviction();
        test_flush();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_ways.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
bench/dcache_chk.sv
bench/dcache_tb.sv

//--- Makefile
# Verilator simulation of the data cache

TOP       ?= dcache_tb
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
